/* int_issue.f */
cpu_params.sv
uop_types.sv
fu_alu.sv
phys_reg_file.sv
int_rs_ordered.sv
int_issue_top.sv
tb_int_issue_properties.sv
tb_int_issue.sv

/* Makefile */
SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_int_issue and check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_int_issue \
		-f int_issue.f -o sim_int_issue
	./obj_dir/sim_int_issue | tee $(SIM_LOG)
	grep -q "ALL CHECKS PASSED" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

/* tb_int_issue.sv */
`timescale 1ns/1ps

module tb_int_issue;

    localparam int RS_DEPTH   = cpu_params::RS_DEPTH_DEFAULT;
    localparam int LANES      = cpu_params::CDB_WIDTH;
    localparam int PHASE_UOPS = 24;
    localparam int PHASES     = 3;
    // registers below this stay zero and are never allocated
    localparam int FIRST_DEST = 8;
    localparam int TIMEOUT    = 50 * PHASE_UOPS * PHASES + 200;

    logic                     clk;
    logic                     rst;
    logic [LANES-1:0]         disp_valid;
    uop_types::dispatch_uop_t disp_uop [LANES];
    logic [LANES-1:0]         disp_ready;
    uop_types::cdb_t          cdb_out [LANES];

    int          seed;
    int          mismatches;
    int          other_errors;
    logic [31:0] model_val [cpu_params::PHY_REGS];
    logic [31:0] exp_value [64];
    logic [4:0]  exp_rd [64];
    bit          exp_live [64];
    bit          exp_ordered [64];
    int          exp_lane [64];
    int          exp_seq [64];
    int          accepted [LANES];
    int          broadcast [LANES];
    int          gen_count [LANES];
    int          last_ordered [LANES];
    int          avail_q [$];
    int          next_rob;
    int          next_dest;
    int          chain_tail;
    bit          saw_full;

    int_issue_top #(.RS_DEPTH(RS_DEPTH)) int_issue_top_inst (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_uop   (disp_uop),
        .disp_ready (disp_ready),
        .cdb_out    (cdb_out)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ////////////////////
    // reference model
    ////////////////////

    function automatic logic [31:0] alu_ref(input uop_types::dispatch_uop_t u,
                                            input logic [31:0] v1, input logic [31:0] v2);
        logic [31:0] a;
        logic [31:0] b;
        a = (u.op1_sel == uop_types::OP1_ZERO) ? 32'd0 : v1;
        b = (u.op2_sel == uop_types::OP2_IMM) ? {{20{u.imm[11]}}, u.imm} : v2;
        case (u.fu_opcode)
            uop_types::ALU_ADD: return a + b;
            uop_types::ALU_SUB: return a - b;
            uop_types::ALU_AND: return a & b;
            uop_types::ALU_OR:  return a | b;
            uop_types::ALU_XOR: return a ^ b;
            uop_types::ALU_SLL: return a << b[4:0];
            uop_types::ALU_SRL: return a >> b[4:0];
            default:            return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // build the next uop of a lane and record what it must broadcast
    task automatic make_uop(input int n, input bit chain);
        uop_types::dispatch_uop_t u;
        int rob;
        rob = next_rob;
        u.rob_id = 6'(rob);
        u.rd_phy = 5'(next_dest);
        if (chain) begin
            // one serial chain through both lanes, each link reads the link made before it
            u.fu_opcode = (n == 0) ? uop_types::ALU_ADD
                                   : uop_types::fu_opcode_t'(3'($random(seed)));
            u.op1_sel = uop_types::OP1_RS1;
            u.op2_sel = (n == 0) ? uop_types::OP2_IMM : uop_types::OP2_RS2;
            u.rs1_phy = 5'(chain_tail);
            u.rs2_phy = 5'(chain_tail);
            chain_tail = next_dest;
        end else begin
            u.fu_opcode = uop_types::fu_opcode_t'(3'($random(seed)));
            u.op1_sel = (($random(seed) & 3) == 0) ? uop_types::OP1_ZERO : uop_types::OP1_RS1;
            u.op2_sel = ($random(seed) & 1) ? uop_types::OP2_IMM : uop_types::OP2_RS2;
            u.rs1_phy = 5'(avail_q[($random(seed) & 32'h7fff_ffff) % avail_q.size()]);
            u.rs2_phy = 5'(avail_q[($random(seed) & 32'h7fff_ffff) % avail_q.size()]);
        end
        u.imm = 12'($random(seed));
        exp_value[rob] = alu_ref(u, model_val[u.rs1_phy], model_val[u.rs2_phy]);
        model_val[u.rd_phy] = exp_value[rob];
        exp_rd[rob] = u.rd_phy;
        exp_live[rob] = 1'b1;
        exp_lane[rob] = n;
        exp_seq[rob] = gen_count[n];
        exp_ordered[rob] = (u.op1_sel == uop_types::OP1_ZERO || u.rs1_phy < FIRST_DEST)
                        && (u.op2_sel == uop_types::OP2_IMM || u.rs2_phy < FIRST_DEST);
        gen_count[n]++;
        next_rob++;
        next_dest++;
        disp_uop[n] = u;
    endtask

    ////////////////////
    // comparison
    ////////////////////

    task automatic check_broadcast(input int k);
        int rob;
        rob = int'(cdb_out[k].rob_id);
        assert (exp_live[rob]) else begin
            other_errors++;
            $display("unexpected broadcast on cdb %0d for rob %0d at %0t", k, rob, $time);
        end
        if (exp_live[rob]) begin
            assert (cdb_out[k].rd_phy == exp_rd[rob]) else begin
                mismatches++;
                $display("Mismatch at %0t: cdb_out[%0d].rd_phy expected %0d got %0d",
                         $time, k, exp_rd[rob], cdb_out[k].rd_phy);
            end
            assert (cdb_out[k].value == exp_value[rob]) else begin
                mismatches++;
                $display("Mismatch at %0t: cdb_out[%0d].value expected %h got %h",
                         $time, k, exp_value[rob], cdb_out[k].value);
            end
            assert (exp_lane[rob] == k) else begin
                other_errors++;
                $display("rob %0d broadcast on the wrong lane at %0t", rob, $time);
            end
            if (exp_ordered[rob]) begin
                assert (exp_seq[rob] > last_ordered[k]) else begin
                    other_errors++;
                    $display("rob %0d overtook an older ready uop at %0t", rob, $time);
                end
                last_ordered[k] = exp_seq[rob];
            end
            exp_live[rob] = 1'b0;
            broadcast[k]++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            for (int k = 0; k < LANES; k++) begin
                if (cdb_out[k].valid) begin
                    check_broadcast(k);
                end
                assert (accepted[k] - broadcast[k] <= RS_DEPTH + 1) else begin
                    other_errors++;
                    $display("lane %0d holds too many uops at %0t", k, $time);
                end
            end
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    task automatic apply_reset();
        rst = 1'b1;
        disp_valid = '0;
        for (int n = 0; n < LANES; n++) begin
            disp_uop[n] = '0;
            accepted[n] = 0;
            broadcast[n] = 0;
            gen_count[n] = 0;
            last_ordered[n] = -1;
        end
        for (int r = 0; r < cpu_params::PHY_REGS; r++) begin
            model_val[r] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            exp_live[i] = 1'b0;
        end
        avail_q.delete();
        for (int r = 0; r < FIRST_DEST; r++) begin
            avail_q.push_back(r);
        end
        next_rob = 0;
        next_dest = FIRST_DEST;
        chain_tail = 0;
        saw_full = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic run_phase(input bit chain);
        bit take [LANES];
        int quota [LANES];
        bit busy;
        apply_reset();
        for (int n = 0; n < LANES; n++) begin
            quota[n] = PHASE_UOPS / LANES;
        end
        // quiet lanes before any dispatch
        repeat (2) begin
            @(negedge clk);
            assert (disp_ready == '1) else begin
                other_errors++;
                $display("disp_ready low after reset at %0t", $time);
            end
        end
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            for (int n = 0; n < LANES; n++) begin
                take[n] = disp_valid[n] && disp_ready[n];
            end
            if (chain && !disp_ready[1]) begin
                saw_full = 1'b1;
            end
            @(posedge clk);
            #1;
            busy = 1'b0;
            for (int n = 0; n < LANES; n++) begin
                if (take[n]) begin
                    disp_valid[n] = 1'b0;
                    accepted[n]++;
                    avail_q.push_back(int'(disp_uop[n].rd_phy));
                end
                // chain pairs go out only when both lanes take them at the next edge
                if (!disp_valid[n] && quota[n] > 0
                        && (chain ? disp_ready == '1 : ($random(seed) & 3) != 0)) begin
                    make_uop(n, chain);
                    quota[n]--;
                    disp_valid[n] = 1'b1;
                end
                busy = busy || disp_valid[n] || quota[n] > 0;
            end
        end
        while (broadcast[0] + broadcast[1] < accepted[0] + accepted[1]) begin
            @(negedge clk);
            #1;
        end
        repeat (3) @(posedge clk);
        #1;
        assert (accepted[0] + accepted[1] == PHASE_UOPS) else begin
            other_errors++;
            $display("only %0d uops accepted in this phase", accepted[0] + accepted[1]);
        end
        if (chain) begin
            assert (saw_full) else begin
                other_errors++;
                $display("lane 1 never filled behind the chain");
            end
        end
    endtask

    initial begin
        seed = 32'he03f_7912;
        mismatches = 0;
        other_errors = 0;
        run_phase(1'b0);
        run_phase(1'b0);
        run_phase(1'b1);
        $display("mismatches: %0d, other errors: %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("run stopped by the watchdog after %0d cycles", TIMEOUT);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* tb_int_issue_properties.sv */
`timescale 1ns/1ps

module int_rs_properties #(
    parameter int RS_DEPTH = cpu_params::RS_DEPTH_DEFAULT
) (
    input logic                             clk,
    input logic                             rst,
    input logic                             disp_ready,
    input logic [$clog2(RS_DEPTH + 1)-1:0]  fill_cnt,
    input logic                             issue_en,
    input logic [((RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1)-1:0] issue_idx,
    input logic                             alu_valid
);

    // a full station must not grow
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        !disp_ready |=> fill_cnt <= $past(fill_cnt))
        else $error("station grew while disp_ready was low");

    fill_in_range: assert property (@(posedge clk) disable iff (rst)
        fill_cnt <= RS_DEPTH)
        else $error("fill count above station depth");

    // alu strobe cleared by reset
    alu_idle_after_reset: assert property (@(posedge clk)
        rst |=> !alu_valid)
        else $error("alu valid high right after reset");

    issue_from_occupied: assert property (@(posedge clk) disable iff (rst)
        issue_en |-> issue_idx < fill_cnt)
        else $error("issue selected an empty slot");

endmodule

bind int_rs_ordered int_rs_properties #(.RS_DEPTH(RS_DEPTH)) int_rs_properties_inst (
    .clk        (clk),
    .rst        (rst),
    .disp_ready (disp_ready),
    .fill_cnt   (fill_cnt),
    .issue_en   (issue_en),
    .issue_idx  (issue_idx),
    .alu_valid  (cdb_out.valid)
);

/* int_issue_top.sv */
`timescale 1ns/1ps

module int_issue_top #(
    parameter int RS_DEPTH = cpu_params::RS_DEPTH_DEFAULT
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [cpu_params::CDB_WIDTH-1:0]  disp_valid,
    input  uop_types::dispatch_uop_t          disp_uop [cpu_params::CDB_WIDTH],
    output logic [cpu_params::CDB_WIDTH-1:0]  disp_ready,
    output uop_types::cdb_t                   cdb_out  [cpu_params::CDB_WIDTH]
);

    // each lane owns one result bus
    localparam int LANES = cpu_params::CDB_WIDTH;

    uop_types::cdb_t                cdb         [LANES];
    logic [cpu_params::PHY_IDX-1:0] src_phy     [LANES][2];
    logic [1:0]                     src_ready   [LANES];
    logic [LANES-1:0]               alloc_valid;
    logic [cpu_params::PHY_IDX-1:0] alloc_phy   [LANES];
    logic [cpu_params::PHY_IDX-1:0] rd_addr     [2*LANES];
    logic [cpu_params::XLEN-1:0]    rd_value    [2*LANES];

    ////////////////////
    // issue lanes
    ////////////////////

    for (genvar n = 0; n < LANES; n++) begin : g_lane
        // lookup and allocation straight from the dispatch port
        assign src_phy[n][0]  = disp_uop[n].rs1_phy;
        assign src_phy[n][1]  = disp_uop[n].rs2_phy;
        assign alloc_valid[n] = disp_valid[n] && disp_ready[n];
        assign alloc_phy[n]   = disp_uop[n].rd_phy;

        int_rs_ordered #(
            .RS_DEPTH (RS_DEPTH)
        ) int_rs_inst (
            .clk        (clk),
            .rst        (rst),
            .disp_valid (disp_valid[n]),
            .disp_uop   (disp_uop[n]),
            .disp_ready (disp_ready[n]),
            .src_ready  (src_ready[n]),
            .rs1_phy    (rd_addr[2*n]),
            .rs2_phy    (rd_addr[2*n+1]),
            .rs1_value  (rd_value[2*n]),
            .rs2_value  (rd_value[2*n+1]),
            .cdb        (cdb),
            .cdb_out    (cdb[n])
        );
    end

    ////////////////////
    // shared register file
    ////////////////////

    phys_reg_file prf_inst (
        .clk            (clk),
        .rst            (rst),
        .disp_src_phy   (src_phy),
        .disp_src_ready (src_ready),
        .alloc_valid    (alloc_valid),
        .alloc_phy      (alloc_phy),
        .rd_phy_addr    (rd_addr),
        .rd_value       (rd_value),
        .cdb            (cdb)
    );

    assign cdb_out = cdb;

endmodule

/* int_rs_ordered.sv */
`timescale 1ns/1ps

module int_rs_ordered #(
    parameter int RS_DEPTH = cpu_params::RS_DEPTH_DEFAULT
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           disp_valid,
    input  uop_types::dispatch_uop_t       disp_uop,
    output logic                           disp_ready,
    input  logic [1:0]                     src_ready,
    output logic [cpu_params::PHY_IDX-1:0] rs1_phy,
    output logic [cpu_params::PHY_IDX-1:0] rs2_phy,
    input  logic [cpu_params::XLEN-1:0]    rs1_value,
    input  logic [cpu_params::XLEN-1:0]    rs2_value,
    input  uop_types::cdb_t                cdb [cpu_params::CDB_WIDTH],
    output uop_types::cdb_t                cdb_out
);

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    // slot 0 holds the oldest entry
    uop_types::int_rs_entry_t  rs_array   [RS_DEPTH];
    uop_types::int_rs_entry_t  woken      [RS_DEPTH];
    uop_types::int_rs_entry_t  rs_next    [RS_DEPTH];
    uop_types::rs_update_sel_t update_sel [RS_DEPTH];

    logic [CNT_W-1:0]          fill_cnt;
    logic [CNT_W-1:0]          fill_next;
    logic [CNT_W-1:0]          push_idx;
    logic                      push_en;
    logic                      pop_en;

    logic                      issue_en;
    logic [IDX_W-1:0]          issue_idx;
    uop_types::int_rs_entry_t  issue_entry;
    uop_types::alu_issue_t     alu_in;

    ////////////////////
    // wakeup
    ////////////////////

    // stored bits plus this cycle's broadcasts
    always_comb begin : cdb_wakeup
        for (int i = 0; i < RS_DEPTH; i++) begin
            woken[i] = rs_array[i];
            for (int k = 0; k < cpu_params::CDB_WIDTH; k++) begin
                if (cdb[k].valid && cdb[k].rd_phy == rs_array[i].uop.rs1_phy) begin
                    woken[i].rs1_valid = 1'b1;
                end
                if (cdb[k].valid && cdb[k].rd_phy == rs_array[i].uop.rs2_phy) begin
                    woken[i].rs2_valid = 1'b1;
                end
            end
        end
    end

    ////////////////////
    // issue select
    ////////////////////

    // lowest occupied slot with both operands available
    always_comb begin : issue_select
        logic op1_rdy;
        logic op2_rdy;
        issue_en  = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            op1_rdy = (woken[i].uop.op1_sel == uop_types::OP1_ZERO) || woken[i].rs1_valid;
            op2_rdy = (woken[i].uop.op2_sel == uop_types::OP2_IMM) || woken[i].rs2_valid;
            if (!issue_en && (CNT_W'(i) < fill_cnt) && op1_rdy && op2_rdy) begin
                issue_en  = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
    end

    ////////////////////
    // push and pop
    ////////////////////

    // ready reflects free slots before this cycle's issue
    assign disp_ready = (fill_cnt < CNT_W'(RS_DEPTH));
    assign push_en    = disp_valid && disp_ready;

    // ALU never stalls so every issue pops
    assign pop_en     = issue_en;
    assign push_idx   = fill_cnt - CNT_W'(pop_en);
    assign fill_next  = push_idx + CNT_W'(push_en);

    always_comb begin : compress_control
        for (int i = 0; i < RS_DEPTH; i++) begin
            update_sel[i] = uop_types::SELF;
            if (pop_en && (IDX_W'(i) >= issue_idx)) begin
                update_sel[i] = uop_types::PREV;
            end
            if (push_en && (CNT_W'(i) == push_idx)) begin
                update_sel[i] = uop_types::PUSH_IN;
            end
        end
    end

    // woken bits move down with the entry
    always_comb begin : compress_mux
        for (int i = 0; i < RS_DEPTH; i++) begin
            case (update_sel[i])
                uop_types::PREV: begin
                    rs_next[i] = woken[(i < RS_DEPTH - 1) ? i + 1 : i];
                end
                uop_types::PUSH_IN: begin
                    rs_next[i].uop       = disp_uop;
                    rs_next[i].rs1_valid = src_ready[0];
                    rs_next[i].rs2_valid = src_ready[1];
                end
                default: begin
                    rs_next[i] = woken[i];
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_cnt <= '0;
        end else begin
            fill_cnt <= fill_next;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            rs_array[i] <= rs_next[i];
        end
    end

    ////////////////////
    // operand read and ALU
    ////////////////////

    assign issue_entry = rs_array[issue_idx];
    assign rs1_phy     = issue_entry.uop.rs1_phy;
    assign rs2_phy     = issue_entry.uop.rs2_phy;

    always_comb begin
        alu_in.rob_id    = issue_entry.uop.rob_id;
        alu_in.rd_phy    = issue_entry.uop.rd_phy;
        alu_in.fu_opcode = issue_entry.uop.fu_opcode;
        alu_in.op1_sel   = issue_entry.uop.op1_sel;
        alu_in.op2_sel   = issue_entry.uop.op2_sel;
        alu_in.imm       = issue_entry.uop.imm;
        // register file already forwards same-cycle broadcasts
        alu_in.rs1_value = rs1_value;
        alu_in.rs2_value = rs2_value;
    end

    fu_alu fu_alu_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_en),
        .issue       (alu_in),
        .cdb_out     (cdb_out)
    );

endmodule

/* phys_reg_file.sv */
`timescale 1ns/1ps

module phys_reg_file (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cpu_params::PHY_IDX-1:0] disp_src_phy   [cpu_params::CDB_WIDTH][2],
    output logic [1:0]                     disp_src_ready [cpu_params::CDB_WIDTH],
    input  logic [cpu_params::CDB_WIDTH-1:0] alloc_valid,
    input  logic [cpu_params::PHY_IDX-1:0] alloc_phy      [cpu_params::CDB_WIDTH],
    input  logic [cpu_params::PHY_IDX-1:0] rd_phy_addr    [2*cpu_params::CDB_WIDTH],
    output logic [cpu_params::XLEN-1:0]    rd_value       [2*cpu_params::CDB_WIDTH],
    input  uop_types::cdb_t                cdb            [cpu_params::CDB_WIDTH]
);

    // one lane per result bus
    localparam int LANES = cpu_params::CDB_WIDTH;

    logic [cpu_params::XLEN-1:0]     reg_value [cpu_params::PHY_REGS];
    logic [cpu_params::PHY_REGS-1:0] reg_ready;

    // dispatch lookup, lane 0 counts as older than lane 1 in the same cycle
    always_comb begin : src_lookup
        for (int n = 0; n < LANES; n++) begin
            for (int s = 0; s < 2; s++) begin
                disp_src_ready[n][s] = reg_ready[disp_src_phy[n][s]];
                for (int k = 0; k < cpu_params::CDB_WIDTH; k++) begin
                    if (cdb[k].valid && cdb[k].rd_phy == disp_src_phy[n][s]) begin
                        disp_src_ready[n][s] = 1'b1;
                    end
                end
                for (int m = 0; m < n; m++) begin
                    if (alloc_valid[m] && alloc_phy[m] == disp_src_phy[n][s]) begin
                        disp_src_ready[n][s] = 1'b0;
                    end
                end
            end
        end
    end

    // operand reads with same-cycle cdb forwarding
    always_comb begin : operand_read
        for (int p = 0; p < 2 * LANES; p++) begin
            rd_value[p] = reg_value[rd_phy_addr[p]];
            for (int k = 0; k < cpu_params::CDB_WIDTH; k++) begin
                if (cdb[k].valid && cdb[k].rd_phy == rd_phy_addr[p]) begin
                    rd_value[p] = cdb[k].value;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_ready <= '1;
            for (int r = 0; r < cpu_params::PHY_REGS; r++) begin
                reg_value[r] <= '0;
            end
        end else begin
            // busy on allocation
            for (int n = 0; n < LANES; n++) begin
                if (alloc_valid[n]) begin
                    reg_ready[alloc_phy[n]] <= 1'b0;
                end
            end
            // cdb writeback
            for (int k = 0; k < cpu_params::CDB_WIDTH; k++) begin
                if (cdb[k].valid) begin
                    reg_value[cdb[k].rd_phy] <= cdb[k].value;
                    reg_ready[cdb[k].rd_phy] <= 1'b1;
                end
            end
        end
    end

endmodule

/* fu_alu.sv */
`timescale 1ns/1ps

module fu_alu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_valid,
    input  uop_types::alu_issue_t issue,
    output uop_types::cdb_t       cdb_out
);

    logic [cpu_params::XLEN-1:0]        op_a;
    logic [cpu_params::XLEN-1:0]        op_b;
    logic [cpu_params::SHAMT_WIDTH-1:0] shamt;
    logic [cpu_params::XLEN-1:0]        result;

    logic                               valid_q;
    logic [cpu_params::ROB_IDX-1:0]     rob_id_q;
    logic [cpu_params::PHY_IDX-1:0]     rd_phy_q;
    logic [cpu_params::XLEN-1:0]        value_q;

    // operand muxes
    assign op_a = (issue.op1_sel == uop_types::OP1_ZERO) ? '0 : issue.rs1_value;
    assign op_b = (issue.op2_sel == uop_types::OP2_IMM)
                ? {{(cpu_params::XLEN - cpu_params::IMM_WIDTH){issue.imm[cpu_params::IMM_WIDTH-1]}},
                   issue.imm}
                : issue.rs2_value;
    assign shamt = op_b[cpu_params::SHAMT_WIDTH-1:0];

    always_comb begin
        case (issue.fu_opcode)
            uop_types::ALU_ADD: result = op_a + op_b;
            uop_types::ALU_SUB: result = op_a - op_b;
            uop_types::ALU_AND: result = op_a & op_b;
            uop_types::ALU_OR:  result = op_a | op_b;
            uop_types::ALU_XOR: result = op_a ^ op_b;
            uop_types::ALU_SLL: result = op_a << shamt;
            uop_types::ALU_SRL: result = op_a >> shamt;
            uop_types::ALU_SLT: result = {{(cpu_params::XLEN-1){1'b0}},
                                          $signed(op_a) < $signed(op_b)};
            default:            result = '0;
        endcase
    end

    // broadcast strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid;
        end
    end

    // result payload, only loaded on issue
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            rob_id_q <= issue.rob_id;
            rd_phy_q <= issue.rd_phy;
            value_q  <= result;
        end
    end

    assign cdb_out = '{valid: valid_q, rob_id: rob_id_q, rd_phy: rd_phy_q, value: value_q};

endmodule

/* uop_types.sv */
package uop_types;

    ////////////////////
    // encodings
    ////////////////////

    // integer ALU operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } fu_opcode_t;

    // operand one source
    typedef enum logic {
        OP1_RS1  = 1'b0,
        OP1_ZERO = 1'b1
    } op1_sel_t;

    // operand two source
    typedef enum logic {
        OP2_RS2 = 1'b0,
        OP2_IMM = 1'b1
    } op2_sel_t;

    // next content of a station slot
    typedef enum logic [1:0] {
        SELF    = 2'd0,
        PREV    = 2'd1,
        PUSH_IN = 2'd2
    } rs_update_sel_t;

    ////////////////////
    // payloads
    ////////////////////

    typedef struct packed {
        logic [cpu_params::ROB_IDX-1:0]   rob_id;
        logic [cpu_params::PHY_IDX-1:0]   rs1_phy;
        logic [cpu_params::PHY_IDX-1:0]   rs2_phy;
        logic [cpu_params::PHY_IDX-1:0]   rd_phy;
        op1_sel_t                         op1_sel;
        op2_sel_t                         op2_sel;
        logic [cpu_params::IMM_WIDTH-1:0] imm;
        fu_opcode_t                       fu_opcode;
    } dispatch_uop_t;

    // uop plus source readiness while it waits
    typedef struct packed {
        dispatch_uop_t uop;
        logic          rs1_valid;
        logic          rs2_valid;
    } int_rs_entry_t;

    typedef struct packed {
        logic [cpu_params::ROB_IDX-1:0]   rob_id;
        logic [cpu_params::PHY_IDX-1:0]   rd_phy;
        fu_opcode_t                       fu_opcode;
        op1_sel_t                         op1_sel;
        op2_sel_t                         op2_sel;
        logic [cpu_params::IMM_WIDTH-1:0] imm;
        logic [cpu_params::XLEN-1:0]      rs1_value;
        logic [cpu_params::XLEN-1:0]      rs2_value;
    } alu_issue_t;

    // one result broadcast
    typedef struct packed {
        logic                           valid;
        logic [cpu_params::ROB_IDX-1:0] rob_id;
        logic [cpu_params::PHY_IDX-1:0] rd_phy;
        logic [cpu_params::XLEN-1:0]    value;
    } cdb_t;

endpackage

/* cpu_params.sv */
package cpu_params;

    ////////////////////
    // datapath
    ////////////////////

    // integer register width
    parameter int XLEN = 32;

    // immediate field carried by a uop, sign-extended in the ALU
    parameter int IMM_WIDTH = 12;

    // shift amount bits taken from operand two
    parameter int SHAMT_WIDTH = $clog2(XLEN);

    ////////////////////
    // register naming
    ////////////////////

    // physical register file
    parameter int PHY_REGS = 32;
    parameter int PHY_IDX  = $clog2(PHY_REGS);

    // reorder buffer tag
    parameter int ROB_IDX = 6;

    ////////////////////
    // issue back end
    ////////////////////

    // one result bus per issue lane
    parameter int CDB_WIDTH = 2;

    // station entries unless the top level overrides
    parameter int RS_DEPTH_DEFAULT = 4;

endpackage
